/* tb.f */
shim_chan_pkg.sv
shim_cfg_pkg.sv
lockstep_fifo.sv
shim_buffer_lockstep.sv
tx_issuer.sv
mem_target.sv
mpf_lockstep_top.sv
tb_mpf_lockstep_assertions.sv
tb_mpf_lockstep.sv

/* tb_mpf_lockstep.sv */
// Testbench for the memory request shim
// Sends directed and random lock-step entries from a fixed seed, keeps a
// model memory and checks every response pulse in entry order.

module tb_mpf_lockstep;

    timeunit 1ns;
    timeprecision 1ps;

    import shim_chan_pkg::*;

    localparam int N_WORDS    = 2 ** $bits(addr_t);
    localparam int N_RANDOM   = 500;
    localparam int WAIT_LIMIT = 2000;

    // One response the model expects, write responses ignore data
    typedef struct packed {
        logic  is_read;
        tag_t  tag;
        data_t data;
    } exp_rsp_t;

    logic     clk;
    logic     rst_n;
    c0_tx_t   c0_tx;
    c1_tx_t   c1_tx;
    logic     almost_full;
    c0_rx_t   c0_rx;
    c1_rx_t   c1_rx;

    // Reference memory and the queue of responses still to come
    data_t    model_mem [N_WORDS];
    exp_rsp_t exp_q [$];
    int       n_expected;
    int       n_received;
    logic     af_seen;

    mpf_lockstep_top u_mpf_lockstep_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .c0_tx       (c0_tx),
        .c1_tx       (c1_tx),
        .almost_full (almost_full),
        .c0_rx       (c0_rx),
        .c1_rx       (c1_rx)
    );

    // 40 ns clock period
    always #20 clk = ~clk;

    // ==================================================
    // Reporting
    // ==================================================

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    task automatic check_value(input string what, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("Error at %0d ns: %s is %0h, expected %0h",
                                $time, what, actual, expected));
        end
    endtask

    // ==================================================
    // Stimulus helpers
    // ==================================================

    function automatic c0_tx_t make_read(input tag_t tag, input addr_t addr);
        make_read = '{valid: 1'b1, tag: tag, addr: addr};
    endfunction

    function automatic c1_tx_t make_write(input tag_t tag, input addr_t addr, input data_t data);
        make_write = '{valid: 1'b1, tag: tag, addr: addr, data: data};
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // Client holds off while almost_full is high
    task automatic wait_for_space();
        int guard;
        guard = 0;
        while (almost_full) begin
            @(posedge clk);
            #2;
            guard++;
            if (guard > WAIT_LIMIT) begin
                abort_run("Timeout: almost_full stayed high and the buffer never drained");
            end
        end
    endtask

    // Drives one entry for a single edge and records what it should return
    task automatic send_entry(input c0_tx_t rd, input c1_tx_t wr);
        exp_rsp_t rsp;
        wait_for_space();
        c0_tx = rd;
        c1_tx = wr;
        // Write goes first within an entry, so a read of the same word sees it
        if (wr.valid) begin
            model_mem[wr.addr] = wr.data;
            rsp = '{is_read: 1'b0, tag: wr.tag, data: '0};
            exp_q.push_back(rsp);
            n_expected++;
        end
        if (rd.valid) begin
            rsp = '{is_read: 1'b1, tag: rd.tag, data: model_mem[rd.addr]};
            exp_q.push_back(rsp);
            n_expected++;
        end
        @(posedge clk);
        #2;
        c0_tx = '0;
        c1_tx = '0;
    endtask

    // Read only, write only, or both, with random fields
    task automatic send_random_entry();
        c0_tx_t rd;
        c1_tx_t wr;
        int     kind;
        kind = $urandom_range(2, 0);
        rd = make_read(tag_t'($urandom), addr_t'($urandom));
        wr = make_write(tag_t'($urandom), addr_t'($urandom), data_t'($urandom));
        if (kind == 0) begin
            rd.valid = 1'b0;
        end else if (kind == 1) begin
            wr.valid = 1'b0;
        end
        send_entry(rd, wr);
    endtask

    // ==================================================
    // Response monitor
    // ==================================================

    // Outputs are registered, so they are stable at the falling edge
    always @(negedge clk) begin
        exp_rsp_t head;
        if (rst_n) begin
            if (almost_full) begin
                af_seen = 1'b1;
            end
            if (u_mpf_lockstep_top.u_assertions.n_failures != 0) begin
                abort_run("A protocol assertion failed");
            end
            // The write of an entry always comes back first
            if (c1_rx.valid) begin
                if (exp_q.size() == 0) begin
                    abort_run("A write response arrived with nothing outstanding");
                end
                head = exp_q.pop_front();
                n_received++;
                check_value("write response kind", 64'(1'b0), 64'(head.is_read));
                check_value("write response tag", 64'(c1_rx.tag), 64'(head.tag));
            end
            if (c0_rx.valid) begin
                if (exp_q.size() == 0) begin
                    abort_run("A read response arrived with nothing outstanding");
                end
                head = exp_q.pop_front();
                n_received++;
                check_value("read response kind", 64'(1'b1), 64'(head.is_read));
                check_value("read response tag", 64'(c0_rx.tag), 64'(head.tag));
                check_value("read response data", 64'(c0_rx.data), 64'(head.data));
            end
        end
    end

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        int n_sent;
        int guard;
        void'($urandom(74));
        clk        = 1'b0;
        rst_n      = 1'b0;
        c0_tx      = '0;
        c1_tx      = '0;
        n_expected = 0;
        n_received = 0;
        af_seen    = 1'b0;
        foreach (model_mem[i]) begin
            model_mem[i] = '0;
        end
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        idle_cycles(1);

        check_value("almost_full after reset", 64'(almost_full), 64'(0));
        check_value("read valid after reset", 64'(c0_rx.valid), 64'(0));
        check_value("write valid after reset", 64'(c1_rx.valid), 64'(0));

        // Every word starts out as zero
        for (int a = 0; a < N_WORDS; a++) begin
            send_entry(make_read(tag_t'(a), addr_t'(a)), '0);
        end

        // Write alone, then read the same word back later
        send_entry('0, make_write(4'h3, 4'h5, 32'hcafe_0005));
        idle_cycles(3);
        send_entry(make_read(4'h4, 4'h5), '0);

        // Both channels on one address, read must see the new word
        send_entry(make_read(4'h7, 4'h9), make_write(4'h6, 4'h9, 32'h1234_5678));

        // Back-to-back burst to push the buffer past its threshold
        repeat (12) begin
            send_random_entry();
        end

        // Random traffic with idle gaps
        n_sent = 0;
        while (n_sent < N_RANDOM) begin
            if ($urandom_range(3, 0) != 0) begin
                send_random_entry();
                n_sent++;
            end else begin
                idle_cycles(1);
            end
        end

        // Every request sent must come back as one response
        guard = 0;
        while (n_received != n_expected) begin
            idle_cycles(1);
            guard++;
            if (guard > WAIT_LIMIT) begin
                abort_run("Timeout: fewer responses received than requests sent");
            end
        end
        // A few more cycles so a stray extra response would be caught
        idle_cycles(10);

        check_value("almost_full seen high", 64'(af_seen), 64'(1));

        if (u_mpf_lockstep_top.u_assertions.n_failures == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            abort_run("One or more protocol assertions failed");
        end
    end

endmodule

/* tb_mpf_lockstep_assertions.sv */
// Protocol assertions for the memory request shim
// Bound into the top level. Covers the req/ack order, request stability,
// client overflow of the buffer and quiet outputs during reset.

module tb_mpf_lockstep_assertions (
    input logic                   clk,
    input logic                   rst_n,
    input shim_chan_pkg::c0_tx_t  c0_tx,
    input shim_chan_pkg::c1_tx_t  c1_tx,
    input logic                   almost_full,
    input logic                   fifo_full,
    input shim_cfg_pkg::mem_req_t mem_req,
    input logic                   req,
    input logic                   ack,
    input shim_chan_pkg::c0_rx_t  c0_rx,
    input shim_chan_pkg::c1_rx_t  c1_rx
);

    timeunit 1ns;
    timeprecision 1ps;

    // Read from the testbench top to end the run
    int n_failures = 0;

    // ==================================================
    // Four-phase handshake
    // ==================================================

    // Ack only answers a raised req, and req only drops once ack is seen
    a_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
        else begin
            n_failures++;
            $error("ack rose without req");
        end
    a_req_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(req) |-> $past(ack))
        else begin
            n_failures++;
            $error("req fell before ack");
        end
    a_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(ack) |-> !$past(req))
        else begin
            n_failures++;
            $error("ack fell while req was high");
        end

    // Request payload holds for the whole time req is up
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (req && $past(req)) |-> $stable(mem_req))
        else begin
            n_failures++;
            $error("mem_req changed while req was high");
        end

    // Client must never send into a full buffer
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        (c0_tx.valid || c1_tx.valid) |-> !fifo_full)
        else begin
            n_failures++;
            $error("client request while the buffer was full");
        end

    a_quiet_reset: assert property (@(posedge clk)
        !rst_n |-> (!almost_full && !c0_rx.valid && !c1_rx.valid && !req && !ack))
        else begin
            n_failures++;
            $error("outputs active during reset");
        end

endmodule

bind mpf_lockstep_top tb_mpf_lockstep_assertions u_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .c0_tx       (c0_tx),
    .c1_tx       (c1_tx),
    .almost_full (almost_full),
    .fifo_full   (u_buf.u_fifo.full),
    .mem_req     (mem_req),
    .req         (req),
    .ack         (ack),
    .c0_rx       (c0_rx),
    .c1_rx       (c1_rx)
);

/* mpf_lockstep_top.sv */
// Memory request shim, top level
// Lock-step buffer, request issuer and memory target joined together.
// The client sees valid plus almost-full on transmit and bare response
// pulses on receive.

module mpf_lockstep_top #(
    parameter int N_ENTRIES = shim_cfg_pkg::DEF_N_ENTRIES,
    parameter int THRESHOLD = shim_cfg_pkg::DEF_THRESHOLD
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  shim_chan_pkg::c0_tx_t c0_tx,
    input  shim_chan_pkg::c1_tx_t c1_tx,
    output logic                  almost_full,
    output shim_chan_pkg::c0_rx_t c0_rx,
    output shim_chan_pkg::c1_rx_t c1_rx
);

    import shim_chan_pkg::*;
    import shim_cfg_pkg::*;

    // Buffer head toward the issuer
    c0_tx_t   head_c0;
    c1_tx_t   head_c1;
    logic     deq;

    // Four-phase link between issuer and target
    mem_req_t mem_req;
    logic     req;
    logic     ack;

    // Responses from the target, routed back through the buffer
    c0_rx_t   c0_rx_mem;
    c1_rx_t   c1_rx_mem;

    shim_buffer_lockstep #(
        .N_ENTRIES   (N_ENTRIES),
        .THRESHOLD   (THRESHOLD)
    ) u_buf (
        .clk         (clk),
        .rst_n       (rst_n),
        .c0_tx       (c0_tx),
        .c1_tx       (c1_tx),
        .almost_full (almost_full),
        .head_c0     (head_c0),
        .head_c1     (head_c1),
        .deq         (deq),
        .c0_rx_in    (c0_rx_mem),
        .c1_rx_in    (c1_rx_mem),
        .c0_rx       (c0_rx),
        .c1_rx       (c1_rx)
    );

    tx_issuer u_issuer (
        .clk     (clk),
        .rst_n   (rst_n),
        .head_c0 (head_c0),
        .head_c1 (head_c1),
        .deq     (deq),
        .mem_req (mem_req),
        .req     (req),
        .ack     (ack)
    );

    mem_target u_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem_req (mem_req),
        .req     (req),
        .ack     (ack),
        .c0_rx   (c0_rx_mem),
        .c1_rx   (c1_rx_mem)
    );

endmodule

/* mem_target.sv */
// Memory target
// A 16-word register memory served over a four-phase req/ack
// handshake. Each access produces a one-cycle response pulse on the
// matching receive channel.

module mem_target (
    input  logic                   clk,
    input  logic                   rst_n,
    input  shim_cfg_pkg::mem_req_t mem_req,
    input  logic                   req,
    output logic                   ack,
    output shim_chan_pkg::c0_rx_t  c0_rx,
    output shim_chan_pkg::c1_rx_t  c1_rx
);

    import shim_chan_pkg::*;
    import shim_cfg_pkg::*;

    // One word per address value
    localparam int N_WORDS = 2 ** $bits(addr_t);

    data_t mem [N_WORDS];

    logic access;

    // New request is seen on the first edge with req high and ack low.
    // Ack stays high until req drops, so each handshake gives one access
    assign access = req && !ack;

    // ==================================================
    // Handshake, storage and responses
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Memory contents start at zero
            mem   <= '{default: '0};
            ack   <= 1'b0;
            c0_rx <= '0;
            c1_rx <= '0;
        end else begin
            // Ack follows req one cycle later, both on rise and on fall
            ack <= req;

            // Responses are pulses, cleared unless an access happens now
            c0_rx <= '0;
            c1_rx <= '0;

            if (access) begin
                if (mem_req.op == MEM_WRITE) begin
                    mem[mem_req.addr] <= mem_req.data;
                    c1_rx <= '{valid: 1'b1, tag: mem_req.tag};
                end else begin
                    // Read sees the stored word before any update in this cycle
                    c0_rx <= '{valid: 1'b1, tag: mem_req.tag,
                               data: mem[mem_req.addr]};
                end
            end
        end
    end

endmodule

/* tx_issuer.sv */
// Request issuer
// Drains the lock-step buffer one entry at a time. The write of an
// entry is issued before its read, each over a four-phase req/ack
// handshake, and the entry is dequeued once both are done.

module tx_issuer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  shim_chan_pkg::c0_tx_t   head_c0,
    input  shim_chan_pkg::c1_tx_t   head_c1,
    output logic                    deq,
    output shim_cfg_pkg::mem_req_t  mem_req,
    output logic                    req,
    input  logic                    ack
);

    import shim_cfg_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ,
        ST_RELEASE
    } state_e;

    state_e state;
    state_e state_next;

    logic hs_done;
    logic load_wr;
    logic load_rd;

    // Handshake is finished once req is down and the target has
    // answered by dropping ack
    assign hs_done = !req && !ack;

    // Start the write whenever the head entry carries one
    assign load_wr = (state == ST_IDLE) && head_c1.valid;

    // The read starts from idle for a read-only entry, or right
    // after the write handshake of a mixed entry
    assign load_rd = ((state == ST_IDLE) && !head_c1.valid && head_c0.valid)
                  || ((state == ST_WRITE) && hs_done && head_c0.valid);

    // Single-cycle pulse that retires the head entry
    assign deq = (state == ST_RELEASE);

    // ==================================================
    // Phase sequencing
    // ==================================================

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (head_c1.valid) begin
                    state_next = ST_WRITE;
                end else if (head_c0.valid) begin
                    state_next = ST_READ;
                end
            end
            ST_WRITE: begin
                // Skip the read phase when channel 0 was idle
                if (hs_done) begin
                    state_next = head_c0.valid ? ST_READ : ST_RELEASE;
                end
            end
            ST_READ: begin
                if (hs_done) begin
                    state_next = ST_RELEASE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            req   <= 1'b0;
        end else begin
            state <= state_next;
            // req rises together with the new mem_req and falls once ack is seen
            if (load_wr || load_rd) begin
                req <= 1'b1;
            end else if (ack) begin
                req <= 1'b0;
            end
        end
    end

    // Request payload changes only at the start of a handshake,
    // when ack is already low
    always_ff @(posedge clk) begin
        if (load_wr) begin
            mem_req <= '{op: MEM_WRITE, tag: head_c1.tag, addr: head_c1.addr,
                         data: head_c1.data};
        end else if (load_rd) begin
            mem_req <= '{op: MEM_READ, tag: head_c0.tag, addr: head_c0.addr,
                         data: '0};
        end
    end

endmodule

/* shim_buffer_lockstep.sv */
// Lock-step request buffer
// Holds the read and write requests of one cycle together in a single
// FIFO entry so read/write ordering is kept. Receive channels have no
// back-pressure and pass straight through toward the client.

module shim_buffer_lockstep #(
    parameter int N_ENTRIES,
    parameter int THRESHOLD
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // Client-side transmit channels and their flow control
    input  shim_chan_pkg::c0_tx_t c0_tx,
    input  shim_chan_pkg::c1_tx_t c1_tx,
    output logic                  almost_full,

    // Buffered head toward the issuer, moved only by deq
    output shim_chan_pkg::c0_tx_t head_c0,
    output shim_chan_pkg::c1_tx_t head_c1,
    input  logic                  deq,

    // Receive channels from the memory target and toward the client
    input  shim_chan_pkg::c0_rx_t c0_rx_in,
    input  shim_chan_pkg::c1_rx_t c1_rx_in,
    output shim_chan_pkg::c0_rx_t c0_rx,
    output shim_chan_pkg::c1_rx_t c1_rx
);

    import shim_chan_pkg::*;

    // ==================================================
    // Transmit buffer
    // ==================================================

    localparam int C0_BITS = $bits(c0_tx_t);
    localparam int C1_BITS = $bits(c1_tx_t);
    localparam int TX_BITS = C0_BITS + C1_BITS;

    logic               enq_en;
    logic               not_empty;
    logic [TX_BITS-1:0] first;
    c0_tx_t             c0_first;
    c1_tx_t             c1_first;

    // A request on either channel claims a whole entry. The idle channel
    // is stored too, with its valid bit clear
    assign enq_en = c0_tx.valid || c1_tx.valid;

    // Field order here must match the concatenation on enq_data
    assign {c0_first, c1_first} = first;

    // Valid bits mean nothing while the FIFO is empty, so hide stale
    // contents of the head slot from the issuer
    always_comb begin
        head_c0       = c0_first;
        head_c0.valid = c0_first.valid && not_empty;
        head_c1       = c1_first;
        head_c1.valid = c1_first.valid && not_empty;
    end

    lockstep_fifo #(
        .N_DATA_BITS (TX_BITS),
        .N_ENTRIES   (N_ENTRIES),
        .THRESHOLD   (THRESHOLD)
    ) u_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .enq_data    ({c0_tx, c1_tx}),
        .enq_en      (enq_en),
        .almost_full (almost_full),
        .first       (first),
        .not_empty   (not_empty),
        .deq_en      (deq)
    );

    // Responses are latency sensitive and go to the client unchanged
    assign c0_rx = c0_rx_in;
    assign c1_rx = c1_rx_in;

endmodule

/* lockstep_fifo.sv */
// Register-based FIFO with an almost-full threshold
// The head entry is visible on first without being removed.
// Almost-full is a registered flag derived from the free-slot count.

module lockstep_fifo #(
    parameter int N_DATA_BITS,
    parameter int N_ENTRIES,
    parameter int THRESHOLD
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [N_DATA_BITS-1:0] enq_data,
    input  logic                   enq_en,
    output logic                   almost_full,
    output logic [N_DATA_BITS-1:0] first,
    output logic                   not_empty,
    input  logic                   deq_en
);

    localparam int PTR_BITS = (N_ENTRIES > 1) ? $clog2(N_ENTRIES) : 1;
    localparam int CNT_BITS = $clog2(N_ENTRIES + 1);

    // Entry storage, plain registers with no reset
    logic [N_DATA_BITS-1:0] storage [N_ENTRIES];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                full;
    logic                do_enq;
    logic                do_deq;

    // Pointers wrap at N_ENTRIES, which need not be a power of two
    function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
        ptr_inc = (ptr == PTR_BITS'(N_ENTRIES - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full      = (count == CNT_BITS'(N_ENTRIES));
    assign not_empty = (count != '0);

    // An enqueue into a full FIFO is a client error and is dropped here
    // so that the pointers stay consistent
    assign do_enq = enq_en && !full;
    assign do_deq = deq_en && not_empty;

    // Head of the queue, readable without a dequeue
    assign first = storage[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_enq) begin
            storage[wr_ptr] <= enq_data;
        end
    end

    // ==================================================
    // Pointers, occupancy and almost-full
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            almost_full <= 1'b0;
        end else begin
            if (do_enq) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_deq) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end

            // Simultaneous enqueue and dequeue leave the count unchanged
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // Flag lags the occupancy by one register stage
            almost_full <= (N_ENTRIES - int'(count)) <= THRESHOLD;
        end
    end

endmodule

/* shim_cfg_pkg.sv */
// Memory request shim, configuration and memory-side definitions
// Default buffer sizing and the request format used between the
// request issuer and the memory target.

package shim_cfg_pkg;

    // Depth of the lock-step request buffer in entries
    localparam int DEF_N_ENTRIES = 6;

    // Almost-full rises when this many slots or fewer are free
    localparam int DEF_THRESHOLD = 4;

    // ==================================================
    // Memory-side request
    // ==================================================

    // Operation carried by one req/ack handshake
    typedef enum logic {
        MEM_READ,
        MEM_WRITE
    } mem_op_e;

    // Data is ignored by the target for a read
    typedef struct packed {
        mem_op_e              op;
        shim_chan_pkg::tag_t  tag;
        shim_chan_pkg::addr_t addr;
        shim_chan_pkg::data_t data;
    } mem_req_t;

endpackage

/* shim_chan_pkg.sv */
// Memory request shim, client channel definitions
// Request and response channels seen by the accelerator-side client.
// Channel 0 carries reads and channel 1 carries writes.

package shim_chan_pkg;

    // ==================================================
    // Field widths
    // ==================================================

    // One data word moved by a read or a write
    typedef logic [31:0] data_t;

    // Word address into the 16-word target memory
    typedef logic [3:0] addr_t;

    // Request tag, echoed unchanged in the matching response
    typedef logic [3:0] tag_t;

    // ==================================================
    // Transmit channels, client toward memory
    // ==================================================

    // Read request on channel 0
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        addr_t addr;
    } c0_tx_t;

    // Write request on channel 1
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        addr_t addr;
        data_t data;
    } c1_tx_t;

    // ==================================================
    // Receive channels, memory toward client
    // ==================================================

    // Read response, tag of the request plus the word read
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t data;
    } c0_rx_t;

    // Write response, only the tag comes back
    typedef struct packed {
        logic valid;
        tag_t tag;
    } c1_rx_t;

endpackage
